// ==== filelist.f ====
+incdir+verilog
verilog/i2cCmdPkg.sv
verilog/i2cBusPkg.sv
verilog/i2cCommandDecode.sv
verilog/i2cBitEngine.sv
verilog/i2cByteResult.sv
verilog/i2cMaster.sv
test/i2cSlaveModel.sv
test/i2cMasterTb.sv

// ==== Makefile ====
# Verilator build of the I2C master testbench

SOURCES := $(shell grep '\.sv$$' filelist.f)

# rebuilt only when a listed source, the config header or the pattern file changes
obj_dir/Vi2cMasterTb: filelist.f $(SOURCES) verilog/i2c_config.svh test/i2cPatterns.txt
	verilator --binary -j 0 -Wno-fatal --top-module i2cMasterTb -f filelist.f -o Vi2cMasterTb

# the exit status of the simulator is the test result
run: obj_dir/Vi2cMasterTb
	obj_dir/Vi2cMasterTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== test/i2cPatterns.txt ====
# name op start stop last data ackExp dataExp
# op 0 is write and 1 is read, data and dataExp in hex, slave at 7'h3a
wrAddr 0 1 0 0 74 1 74
wrData0 0 0 0 0 a5 1 a5
wrData1 0 0 0 0 3c 1 3c
wrData2 0 0 0 0 81 1 81
wrData3 0 0 1 0 5e 1 5e
nackAddr 0 1 0 0 42 0 42
nackStop 0 0 1 0 ff 0 ff
rdAddr 0 1 0 0 75 1 75
rdData0 1 0 0 0 00 1 a5
rdData1 1 0 0 0 00 1 3c
rdData2 1 0 0 0 00 1 81
rdData3 1 0 1 1 00 0 5e
wrAddr2 0 1 0 0 74 1 74
wrData4 0 0 0 0 c3 1 c3
wrData5 0 0 0 0 07 1 07
wrData6 0 0 1 0 f0 1 f0
nackAddr2 0 1 1 0 e4 0 e4
rdAddr2 0 1 0 0 75 1 75
rdData4 1 0 0 0 00 1 c3
rdData5 1 0 0 0 00 1 07
rdData6 1 0 1 1 00 0 f0

// ==== test/i2cMasterTb.sv ====
`timescale 1ns/100ps

module i2cMasterTb;

	logic clk = 1'b0;
	logic reset;
	i2cCmdPkg::i2cCmd_t cmd;
	logic cmdValid;
	logic cmdReady;
	i2cCmdPkg::i2cResp_t resp;
	logic respValid;
	logic respReady;
	wire sda;
	wire scl;

	string testName[$]; // one entry per pattern line
	i2cCmdPkg::i2cCmd_t cmdList[$];
	logic expAck[$];
	logic [7:0] expData[$];
	int startCount = 0; // expected bus conditions
	int stopCount = 0;
	int startsSeen = 0;
	int stopsSeen = 0;
	int cycles = 0;
	int cycleLimit = 0;
	logic sclLast = 1'b1;
	logic sdaLast = 1'b1;

	pullup (sda);
	pullup (scl);

	i2cMaster uut
	(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.resp(resp),
		.respValid(respValid),
		.respReady(respReady),
		.sda(sda),
		.scl(scl)
	);

	i2cSlaveModel #(.address(7'h3a)) slave
	(
		.sda(sda),
		.scl(scl)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycleLimit != 0 && cycles > cycleLimit)
		begin
			$display("run timed out after %0d cycles without finishing the patterns", cycles);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	// START and STOP seen on the bus, sampled where the lines are stable
	always @(posedge clk)
	begin
		#1;
		if (sclLast === 1'b1 && scl === 1'b1 && sdaLast === 1'b1 && sda === 1'b0)
		begin
			startsSeen = startsSeen + 1;
		end
		if (sclLast === 1'b1 && scl === 1'b1 && sdaLast === 1'b0 && sda === 1'b1)
		begin
			stopsSeen = stopsSeen + 1;
		end
		sclLast = scl;
		sdaLast = sda;
	end

	task checkValue(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task readPatterns();
		int fd;
		string line;
		string name;
		int op;
		int st;
		int sp;
		int la;
		int ea;
		int da;
		int ed;
		i2cCmdPkg::i2cCmd_t c;
		fd = $fopen("test/i2cPatterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the pattern file test/i2cPatterns.txt");
			$display("TESTS FAILED");
			$fatal(1);
		end
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() > 1 && line[0] != "#")
			begin
				if ($sscanf(line, "%s %d %d %d %d %h %d %h", name, op, st, sp, la, da, ea, ed) == 8)
				begin
					c.op = i2cCmdPkg::cmdOp_e'(op[0]);
					c.start = st[0];
					c.stop = sp[0];
					c.last = la[0];
					c.data = da[7:0];
					testName.push_back(name);
					cmdList.push_back(c);
					expAck.push_back(ea[0]);
					expData.push_back(ed[7:0]);
					startCount = startCount + st;
					stopCount = stopCount + sp;
				end
			end
		end
		$fclose(fd);
	endtask

	// commands back to back, valid held until decode takes each one
	task sendCommands();
		logic taken;
		foreach (cmdList[i])
		begin
			cmd = cmdList[i];
			cmdValid = 1'b1;
			taken = 1'b0;
			while (!taken)
			begin
				taken = cmdReady; // ready as the coming edge sees it
				@(posedge clk);
				#1;
			end
		end
		cmdValid = 1'b0;
	endtask

	// responses in command order, ready withheld for random lengths
	task collectResponses();
		int hold;
		int waited;
		foreach (cmdList[i])
		begin
			while (respValid !== 1'b1)
			begin
				@(posedge clk);
				#1;
			end
			checkValue({testName[i], " op"}, cmdList[i].op, resp.op);
			checkValue({testName[i], " ack"}, expAck[i], resp.ack);
			checkValue({testName[i], " data"}, expData[i], resp.data);
			if ($urandom % 4 == 0)
			begin
				hold = 250 + $urandom % 30; // long enough to stall the next byte
			end
			else
			begin
				hold = $urandom % 6;
			end
			for (waited = 0; waited < hold; waited++)
			begin
				// next byte is done by now and waits with SCL low
				if (waited >= 240 && i + 1 < cmdList.size())
				begin
					checkValue({testName[i], " scl held"}, 0, scl);
				end
				@(posedge clk);
				#1;
			end
			respReady = 1'b1;
			@(posedge clk);
			#1;
			respReady = 1'b0;
		end
	endtask

	task waitBusIdle();
		while (sda !== 1'b1 || scl !== 1'b1)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk); // lets the bus monitor see the last STOP
		#1;
	endtask

	initial
	begin
		void'($urandom(32'h73b0));
		reset = 1'b0;
		cmd = '0;
		cmdValid = 1'b0;
		respReady = 1'b0;
		readPatterns();
		cycleLimit = cmdList.size() * 300 + 200;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;
		checkValue("reset respValid", 0, respValid);
		checkValue("reset cmdReady", 1, cmdReady);
		checkValue("reset sda", 1, sda);
		checkValue("reset scl", 1, scl);
		fork
			sendCommands();
			collectResponses();
		join
		waitBusIdle();
		checkValue("start count", startCount, startsSeen);
		checkValue("stop count", stopCount, stopsSeen);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== test/i2cSlaveModel.sv ====
`timescale 1ns/100ps

module i2cSlaveModel
#(
	parameter logic [6:0] address = 7'h3a
)
(
	inout wire sda,
	input wire scl
);

	typedef enum
	{
		slvIdle,
		slvAddr,
		slvWrite,
		slvRead,
		slvIgnore
	} slvMode_e;

	slvMode_e mode = slvIdle;
	logic [7:0] mem [0:7]; // filled and read back in increasing order
	logic [2:0] wrPtr = 3'd0;
	logic [2:0] rdPtr = 3'd0;
	logic [7:0] shiftIn = 8'd0; // address or write byte
	logic [7:0] txByte = 8'd0; // byte being returned
	int bitIdx = 0; // 0..7 data, 8 ACK, 9 byte done
	logic masterNack = 1'b0;
	logic sdaLow = 1'b0;
	logic sclPrev = 1'b1;
	logic sdaPrev = 1'b1;
	logic sclNow;
	logic sdaNow;

	assign sda = sdaLow ? 1'b0 : 1'bz; // open drain

	always @(scl or sda)
	begin
		#1; // lines switched by one clk edge settle first
		sclNow = (scl !== 1'b0);
		sdaNow = (sda !== 1'b0);
		if (sclPrev && sclNow && sdaPrev && !sdaNow)
		begin
			mode = slvAddr; // START
			bitIdx = 0;
			sdaLow = 1'b0;
		end
		else if (sclPrev && sclNow && !sdaPrev && sdaNow)
		begin
			mode = slvIdle; // STOP
			sdaLow = 1'b0;
		end
		else if (!sclPrev && sclNow && mode != slvIdle && mode != slvIgnore)
		begin
			if (bitIdx < 8)
			begin
				shiftIn = {shiftIn[6:0], sdaNow}; // MSB first
			end
			else
			begin
				masterNack = sdaNow; // ninth bit as driven by the master
			end
			bitIdx = bitIdx + 1;
		end
		else if (sclPrev && !sclNow && mode != slvIdle && mode != slvIgnore)
		begin
			if (bitIdx == 8)
			begin
				if (mode == slvAddr)
				begin
					if (shiftIn[7:1] == address)
					begin
						sdaLow = 1'b1; // address ACK
					end
					else
					begin
						mode = slvIgnore; // not us, wait for the next START
					end
				end
				else if (mode == slvWrite)
				begin
					mem[wrPtr] = shiftIn;
					wrPtr = wrPtr + 3'd1;
					sdaLow = 1'b1; // data ACK
				end
				else
				begin
					sdaLow = 1'b0; // master owns the ACK bit on reads
				end
			end
			else if (bitIdx == 9)
			begin
				bitIdx = 0;
				sdaLow = 1'b0;
				if (mode == slvAddr)
				begin
					mode = shiftIn[0] ? slvRead : slvWrite; // R/W bit
				end
				else if (mode == slvRead && masterNack)
				begin
					mode = slvIgnore; // master is done reading
				end
				if (mode == slvRead)
				begin
					txByte = mem[rdPtr];
					rdPtr = rdPtr + 3'd1;
					sdaLow = !txByte[7];
				end
			end
			else if (mode == slvRead)
			begin
				sdaLow = !txByte[7 - bitIdx]; // next bit while SCL is low
			end
		end
		sclPrev = sclNow;
		sdaPrev = sdaNow;
	end

endmodule

// ==== verilog/i2cMaster.sv ====
`timescale 1ns/100ps

module i2cMaster
(
	input logic clk,
	input logic reset,
	input i2cCmdPkg::i2cCmd_t cmd,
	input logic cmdValid,
	output logic cmdReady,
	output i2cCmdPkg::i2cResp_t resp,
	output logic respValid,
	input logic respReady,
	inout wire sda,
	inout wire scl
);

	i2cBusPkg::busStep_t step; // decode to engine
	logic stepValid;
	logic stepReady;
	i2cBusPkg::byteOutcome_t outcome; // engine to result
	logic outcomeValid;
	logic outcomeReady;
	logic sclRelease;
	logic sdaRelease;
	logic sdaIn;

	// open-drain, the pull-ups give the high level
	assign scl = sclRelease ? 1'bz : 1'b0;
	assign sda = sdaRelease ? 1'bz : 1'b0;
	assign sdaIn = sda; // wired-AND of master and slave

	i2cCommandDecode decode
	(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.step(step),
		.stepValid(stepValid),
		.stepReady(stepReady)
	);

	i2cBitEngine engine
	(
		.clk(clk),
		.reset(reset),
		.step(step),
		.stepValid(stepValid),
		.stepReady(stepReady),
		.outcome(outcome),
		.outcomeValid(outcomeValid),
		.outcomeReady(outcomeReady),
		.sdaIn(sdaIn),
		.sclRelease(sclRelease),
		.sdaRelease(sdaRelease)
	);

	i2cByteResult result
	(
		.clk(clk),
		.reset(reset),
		.outcome(outcome),
		.outcomeValid(outcomeValid),
		.outcomeReady(outcomeReady),
		.resp(resp),
		.respValid(respValid),
		.respReady(respReady)
	);

endmodule

// ==== verilog/i2cByteResult.sv ====
`timescale 1ns/100ps

module i2cByteResult
(
	input logic clk,
	input logic reset,
	input i2cBusPkg::byteOutcome_t outcome,
	input logic outcomeValid,
	output logic outcomeReady,
	output i2cCmdPkg::i2cResp_t resp,
	output logic respValid,
	input logic respReady
);

	logic take; // outcome moves into the response register

	assign outcomeReady = !respValid; // single entry, full stalls the engine
	assign take = outcomeValid && outcomeReady;

	// response payload
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			resp.op <= outcome.op;
			// ninth bit as seen on SDA
			// master ACK for a read, slave ACK for a write
			resp.ack <= outcome.ack;
			resp.data <= outcome.data;
		end
	end

	// valid flag
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			respValid <= 1'b0;
		end
		else if (take)
		begin
			respValid <= 1'b1; // one cycle after the outcome handshake
		end
		else if (respReady)
		begin
			respValid <= 1'b0; // host took it
		end
	end

endmodule

// ==== verilog/i2cBitEngine.sv ====
`timescale 1ns/100ps

`include "i2c_config.svh"

module i2cBitEngine
(
	input logic clk,
	input logic reset,
	input i2cBusPkg::busStep_t step,
	input logic stepValid,
	output logic stepReady,
	output i2cBusPkg::byteOutcome_t outcome,
	output logic outcomeValid,
	input logic outcomeReady,
	input logic sdaIn,
	output logic sclRelease,
	output logic sdaRelease
);

	localparam logic [`I2C_DIV_WIDTH-1:0] quarterLast = `I2C_QUARTER_CYCLES - 1;
	localparam logic [`I2C_BIT_INDEX_WIDTH-1:0] ackBitIndex = `I2C_DATA_WIDTH; // ninth bit

	i2cBusPkg::enginePhase_e phase;
	logic [`I2C_DIV_WIDTH-1:0] divCount; // clk cycles inside a quarter
	logic [1:0] quarter; // quarter inside the phase
	logic [`I2C_BIT_INDEX_WIDTH-1:0] bitCount; // 0..7 data, 8 ACK
	logic [`I2C_DATA_WIDTH-1:0] shiftReg; // out MSB first, bus samples shift in at the LSB
	logic isRead; // current byte is a byteIn
	logic nackReg; // byteIn answers NACK
	logic activePhase; // divider runs
	logic quarterEnd;
	logic halfEnd; // second quarter of a half done
	logic phaseDone;
	logic txBit; // SDA release value during a bit
	logic stepTake;

	assign activePhase = (phase == i2cBusPkg::phaseStart) || (phase == i2cBusPkg::phaseBitLow)
		|| (phase == i2cBusPkg::phaseBitHigh) || (phase == i2cBusPkg::phaseStop);
	assign quarterEnd = activePhase && (divCount == quarterLast);
	assign halfEnd = quarterEnd && quarter[0];
	// START and STOP span 4 quarters, a bit half spans 2
	assign phaseDone = ((phase == i2cBusPkg::phaseStart) || (phase == i2cBusPkg::phaseStop))
		? (halfEnd && quarter[1]) : halfEnd;

	// no new step while an outcome waits, SCL stays low meanwhile
	assign stepReady = ((phase == i2cBusPkg::phaseIdle) || (phase == i2cBusPkg::phaseHold))
		&& !outcomeValid;
	assign stepTake = stepValid && stepReady;

	always_comb
	begin
		if (bitCount == ackBitIndex)
		begin
			// master ACK on reads, slave drives it on writes
			txBit = isRead ? (nackReg ? `I2C_NACK_LEVEL : `I2C_ACK_LEVEL) : 1'b1;
		end
		else
		begin
			txBit = isRead ? 1'b1 : shiftReg[`I2C_DATA_WIDTH-1]; // slave owns SDA on reads
		end
	end

	// open-drain levels per phase
	always_comb
	begin
		case (phase)
			i2cBusPkg::phaseStart:
			begin
				sclRelease = !quarter[1]; // high first half, low second half
				sdaRelease = 1'b0;
			end
			i2cBusPkg::phaseBitLow:
			begin
				sclRelease = 1'b0;
				sdaRelease = txBit; // SDA moves with SCL low
			end
			i2cBusPkg::phaseBitHigh:
			begin
				sclRelease = 1'b1;
				sdaRelease = txBit;
			end
			i2cBusPkg::phaseStop:
			begin
				sclRelease = quarter[1]; // SDA rises on the way back to idle
				sdaRelease = 1'b0;
			end
			i2cBusPkg::phaseHold:
			begin
				sclRelease = 1'b0; // master keeps the clock
				sdaRelease = 1'b1;
			end
			default:
			begin
				sclRelease = 1'b1;
				sdaRelease = 1'b1;
			end
		endcase
	end

	// quarter divider
	always_ff @(posedge clk)
	begin
		if (!reset || !activePhase)
		begin
			divCount <= '0;
			quarter <= 2'd0;
		end
		else if (quarterEnd)
		begin
			divCount <= '0;
			quarter <= phaseDone ? 2'd0 : quarter + 2'd1;
		end
		else
		begin
			divCount <= divCount + 1'b1;
		end
	end

	// phase machine and bit counter
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			phase <= i2cBusPkg::phaseIdle;
			bitCount <= '0;
			outcomeValid <= 1'b0;
		end
		else
		begin
			if (outcomeValid && outcomeReady)
			begin
				outcomeValid <= 1'b0;
			end
			case (phase)
				i2cBusPkg::phaseIdle, i2cBusPkg::phaseHold:
				begin
					if (stepTake)
					begin
						bitCount <= '0;
						case (step.kind)
							i2cBusPkg::stepStart: phase <= i2cBusPkg::phaseStart;
							i2cBusPkg::stepStop: phase <= i2cBusPkg::phaseStop;
							default: phase <= i2cBusPkg::phaseBitLow;
						endcase
					end
				end
				i2cBusPkg::phaseStart:
				begin
					if (phaseDone)
					begin
						phase <= i2cBusPkg::phaseHold; // both lines low, ready for the byte
					end
				end
				i2cBusPkg::phaseBitLow:
				begin
					if (phaseDone)
					begin
						phase <= i2cBusPkg::phaseBitHigh;
					end
				end
				i2cBusPkg::phaseBitHigh:
				begin
					if (phaseDone)
					begin
						if (bitCount == ackBitIndex)
						begin
							phase <= i2cBusPkg::phaseHold;
							outcomeValid <= 1'b1; // one cycle after the ACK high half
						end
						else
						begin
							phase <= i2cBusPkg::phaseBitLow;
							bitCount <= bitCount + 1'b1;
						end
					end
				end
				i2cBusPkg::phaseStop:
				begin
					if (phaseDone)
					begin
						phase <= i2cBusPkg::phaseIdle;
					end
				end
				default:
				begin
					phase <= i2cBusPkg::phaseIdle;
				end
			endcase
		end
	end

	// byte datapath, loaded per step and sampled at the end of each high half
	always_ff @(posedge clk)
	begin
		if (stepTake)
		begin
			shiftReg <= step.data;
			isRead <= (step.kind == i2cBusPkg::stepByteIn);
			nackReg <= step.nack;
		end
		else if (phase == i2cBusPkg::phaseBitHigh && phaseDone)
		begin
			if (bitCount == ackBitIndex)
			begin
				outcome.op <= isRead ? i2cCmdPkg::cmdRead : i2cCmdPkg::cmdWrite;
				outcome.ack <= (sdaIn == `I2C_ACK_LEVEL);
				outcome.data <= shiftReg; // sampled bits, the echo on a write
			end
			else
			begin
				shiftReg <= {shiftReg[`I2C_DATA_WIDTH-2:0], sdaIn};
			end
		end
	end

endmodule

// ==== verilog/i2cCommandDecode.sv ====
`timescale 1ns/100ps

module i2cCommandDecode
(
	input logic clk,
	input logic reset,
	input i2cCmdPkg::i2cCmd_t cmd,
	input logic cmdValid,
	output logic cmdReady,
	output i2cBusPkg::busStep_t step,
	output logic stepValid,
	input logic stepReady
);

	// which step of the latched command is on offer
	typedef enum logic [1:0]
	{
		decIdle = 2'd0,
		decStart = 2'd1,
		decByte = 2'd2,
		decStop = 2'd3
	} decState_e;

	decState_e state; // step sequencer
	i2cCmdPkg::i2cCmd_t cmdReg; // command being decoded

	assign cmdReady = (state == decIdle); // one command at a time
	assign stepValid = (state != decIdle); // step follows acceptance by one cycle

	always_ff @(posedge clk)
	begin
		if (cmdValid && cmdReady)
		begin
			cmdReg <= cmd; // hold the command for all its steps
		end
	end

	// START, byte, STOP in that order, START and STOP optional
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= decIdle;
		end
		else
		begin
			case (state)
				decIdle:
				begin
					if (cmdValid)
					begin
						state <= cmd.start ? decStart : decByte;
					end
				end
				decStart:
				begin
					if (stepReady)
					begin
						state <= decByte; // START taken by the engine
					end
				end
				decByte:
				begin
					if (stepReady)
					begin
						state <= cmdReg.stop ? decStop : decIdle;
					end
				end
				decStop:
				begin
					if (stepReady)
					begin
						state <= decIdle;
					end
				end
				default:
				begin
					state <= decIdle;
				end
			endcase
		end
	end

	// step payload from the latched command
	always_comb
	begin
		step.data = cmdReg.data; // only byteOut uses it
		step.nack = 1'b0;
		case (state)
			decStart: step.kind = i2cBusPkg::stepStart;
			decStop: step.kind = i2cBusPkg::stepStop;
			default:
			begin
				if (cmdReg.op == i2cCmdPkg::cmdRead)
				begin
					step.kind = i2cBusPkg::stepByteIn;
					step.nack = cmdReg.last; // last read of a burst gets NACK
				end
				else
				begin
					step.kind = i2cBusPkg::stepByteOut;
				end
			end
		endcase
	end

endmodule

// ==== verilog/i2cBusPkg.sv ====
`include "i2c_config.svh"

package i2cBusPkg;

	// what the bit engine has to put on the bus
	typedef enum logic [1:0]
	{
		stepStart = 2'd0, // START from idle
		stepByteOut = 2'd1, // 8 bits out, slave ACK in
		stepByteIn = 2'd2, // 8 bits in, master ACK out
		stepStop = 2'd3 // STOP, bus goes idle
	} busStepKind_e;

	typedef struct packed
	{
		busStepKind_e kind;
		logic [`I2C_DATA_WIDTH-1:0] data; // byteOut payload
		logic nack; // byteIn, release SDA in the ACK bit
	} busStep_t;

	// result of one byte step
	typedef struct packed
	{
		i2cCmdPkg::cmdOp_e op; // derived from the step kind
		logic ack; // ninth bit sampled low
		logic [`I2C_DATA_WIDTH-1:0] data; // 8 bits sampled on SDA
	} byteOutcome_t;

	// bit engine phases
	typedef enum logic [2:0]
	{
		phaseIdle = 3'd0, // both lines released
		phaseStart = 3'd1, // SDA low under high SCL, then SCL low
		phaseBitLow = 3'd2, // SCL low half, SDA set up
		phaseBitHigh = 3'd3, // SCL high half, SDA sampled at the end
		phaseStop = 3'd4, // SCL rises with SDA low
		phaseHold = 3'd5 // SCL held low between steps
	} enginePhase_e;

endpackage

// ==== verilog/i2cCmdPkg.sv ====
`include "i2c_config.svh"

package i2cCmdPkg;

	// host command type
	typedef enum logic
	{
		cmdWrite = 1'b0, // send one byte, address or data
		cmdRead = 1'b1 // fetch one byte from the slave
	} cmdOp_e;

	// one host command, one bus byte with optional START and STOP around it
	typedef struct packed
	{
		cmdOp_e op; // write or read
		logic start; // START before the byte
		logic stop; // STOP after the byte
		logic last; // read only, answer with NACK
		logic [`I2C_DATA_WIDTH-1:0] data; // byte to send, unused on a read
	} i2cCmd_t;

	// one response per command, in command order
	typedef struct packed
	{
		cmdOp_e op; // echo of the command op
		logic ack; // ACK bit was low on the bus
		logic [`I2C_DATA_WIDTH-1:0] data; // read byte, or the byte seen on the bus for a write
	} i2cResp_t;

endpackage

// ==== verilog/i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// clk cycles per quarter of the SCL period
`define I2C_QUARTER_CYCLES 5

// quarter divider counter width
`define I2C_DIV_WIDTH 8

// bits per bus byte without the ACK bit
`define I2C_DATA_WIDTH 8

// bit counter width, counts 8 data bits plus the ACK bit
`define I2C_BIT_INDEX_WIDTH 4

// SDA level in the ninth bit
`define I2C_ACK_LEVEL 1'b0
`define I2C_NACK_LEVEL 1'b1

`endif
